// ==== cache_pkg.sv ====
// Cache package with geometry, MESI encoding and request and response types
package cache_pkg;

    localparam int num_lines      = 256;
    localparam int words_per_line = 4;
    localparam int tag_width      = 20;
    localparam int index_width    = 8;
    localparam int offset_width   = 4;

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        m = 2'b00,  // Modified
        e = 2'b01,  // Exclusive
        s = 2'b10,  // Shared
        i = 2'b11   // Invalid
    } mesi_t;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;  // Byte offset with the word number in [3:2]
    } cache_addr_t;

    // One cache line as flat bus bits or as separate words
    typedef union packed {
        logic [words_per_line*32-1:0]   flat;
        word_t [words_per_line-1:0]     words;
    } cache_line_u;

    typedef struct packed {
        logic        write;
        cache_addr_t addr;
        word_t       wdata;
    } proc_req_t;

    typedef struct packed {
        word_t rdata;
        logic  hit;
    } proc_resp_t;

    typedef struct packed {
        logic        write;  // Write-back of a victim
        logic        excl;   // Refill asked for ownership
        cache_addr_t addr;   // Line aligned
        cache_line_u line;
    } bus_req_t;

    typedef struct packed {
        cache_line_u line;
        mesi_t       state;  // State granted to the refilled line
    } bus_resp_t;

    typedef struct packed {
        cache_addr_t addr;
        mesi_t       new_state;
    } snoop_req_t;

    typedef struct packed {
        logic  hit;
        word_t data;
        mesi_t old_state;
    } snoop_resp_t;

    typedef struct packed {
        logic [tag_width-1:0] tag;
        logic                 valid;
        mesi_t                state;
    } tag_entry_t;

endpackage

// ==== cache_tag_store.sv ====
// Tag store keeping tag, valid bit and MESI state per line, with a flush sweep
`timescale 1ns/1ps

module cache_tag_store (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              lookup_en,
    input  logic [cache_pkg::index_width-1:0] lookup_index,
    output cache_pkg::tag_entry_t             lookup_entry,
    input  logic                              write_en,
    input  logic [cache_pkg::index_width-1:0] write_index,
    input  cache_pkg::tag_entry_t             write_entry,
    input  logic                              flush_start,
    output logic                              flush_busy
);
    import cache_pkg::*;

    logic [tag_width-1:0]   tag_mem   [num_lines];
    logic                   valid_mem [num_lines];
    mesi_t                  state_mem [num_lines];
    logic [index_width-1:0] flush_idx;  // Sweep position

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[write_index] <= write_entry.tag;
        end
    end

    // Valid and state clear on reset and during the sweep
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int idx = 0; idx < num_lines; idx++) begin
                valid_mem[idx] <= 1'b0;
                state_mem[idx] <= i;
            end
        end else if (flush_busy) begin
            valid_mem[flush_idx] <= 1'b0;
            state_mem[flush_idx] <= i;
        end else if (write_en) begin
            valid_mem[write_index] <= write_entry.valid;
            state_mem[write_index] <= write_entry.state;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flush_busy <= 1'b0;
            flush_idx  <= '0;
        end else if (flush_start) begin
            flush_busy <= 1'b1;
            flush_idx  <= '0;
        end else if (flush_busy) begin
            flush_idx <= flush_idx + 1'b1;
            if (flush_idx == index_width'(num_lines - 1)) begin
                flush_busy <= 1'b0;  // Last index cleared this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            lookup_entry.tag   <= tag_mem[lookup_index];
            lookup_entry.valid <= valid_mem[lookup_index];
            lookup_entry.state <= state_mem[lookup_index];
        end
    end

endmodule

// ==== cache_data_store.sv ====
// Data store for all cache lines with word merge and whole-line fill
`timescale 1ns/1ps

module cache_data_store (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          lookup_en,
    input  logic [cache_pkg::index_width-1:0]             lookup_index,
    output cache_pkg::cache_line_u                        lookup_line,
    input  logic                                          write_en,
    input  logic [cache_pkg::index_width-1:0]             write_index,
    input  cache_pkg::cache_line_u                        write_line,
    input  logic                                          word_en,
    input  logic [$clog2(cache_pkg::words_per_line)-1:0]  word_sel,
    input  cache_pkg::word_t                              word_data
);
    import cache_pkg::*;

    cache_line_u line_mem [num_lines];
    cache_line_u merged_line;

    // Replace one word of the incoming line when asked
    always_comb begin
        merged_line = write_line;
        if (word_en) begin
            merged_line.words[word_sel] = word_data;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            line_mem[write_index] <= merged_line;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lookup_line <= '0;
        end else if (lookup_en) begin
            lookup_line <= line_mem[lookup_index];  // One cycle read
        end
    end

endmodule

// ==== cache_ctrl.sv ====
// Cache controller FSM sequencing lookups, write-back, refill, snoops and flush
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          proc_req_valid,
    output logic                                          proc_req_ready,
    input  cache_pkg::proc_req_t                          proc_req,
    output logic                                          proc_resp_valid,
    output cache_pkg::proc_resp_t                         proc_resp,
    output logic                                          bus_req_valid,
    input  logic                                          bus_req_ready,
    output cache_pkg::bus_req_t                           bus_req,
    input  logic                                          bus_resp_valid,
    input  cache_pkg::bus_resp_t                          bus_resp,
    input  logic                                          snoop_req_valid,
    output logic                                          snoop_req_ready,
    input  cache_pkg::snoop_req_t                         snoop_req,
    output logic                                          snoop_resp_valid,
    output cache_pkg::snoop_resp_t                        snoop_resp,
    input  logic                                          flush_valid,
    output logic                                          flush_ready,
    output logic                                          tag_lookup_en,
    output logic [cache_pkg::index_width-1:0]             tag_lookup_index,
    input  cache_pkg::tag_entry_t                         tag_entry,
    output logic                                          tag_write_en,
    output logic [cache_pkg::index_width-1:0]             tag_write_index,
    output cache_pkg::tag_entry_t                         tag_write_entry,
    output logic                                          flush_start,
    input  logic                                          flush_busy,
    output logic                                          data_lookup_en,
    output logic [cache_pkg::index_width-1:0]             data_lookup_index,
    input  cache_pkg::cache_line_u                        data_line,
    output logic                                          data_write_en,
    output logic [cache_pkg::index_width-1:0]             data_write_index,
    output cache_pkg::cache_line_u                        data_write_line,
    output logic                                          data_word_en,
    output logic [$clog2(cache_pkg::words_per_line)-1:0]  data_word_sel,
    output cache_pkg::word_t                              data_word_data
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        idle, lookup, respond, writeback, refill, fill, snoop_check, flush_wait
    } state_t;

    state_t      state_q, state_d;
    logic        run_q;         // Set once reset is released
    logic        snoop_q;       // Current request came from the snooper
    logic        miss_q;        // Refill done and response comes from fill_line_q
    logic        sent_q;        // Refill request already transferred
    cache_addr_t addr_q;
    logic        write_q;
    word_t       wdata_q;
    mesi_t       new_state_q;
    cache_line_u fill_line_q;
    mesi_t       fill_state_q;
    logic        accept_snoop, accept_flush, accept_proc;
    logic        tag_hit;
    logic [$clog2(words_per_line)-1:0] word_sel;

    assign snoop_req_ready = run_q && (state_q == idle);
    assign flush_ready     = snoop_req_ready && !snoop_req_valid;
    assign proc_req_ready  = flush_ready && !flush_valid;
    assign accept_snoop    = snoop_req_valid && snoop_req_ready;
    assign accept_flush    = flush_valid && flush_ready;
    assign accept_proc     = proc_req_valid && proc_req_ready;
    assign flush_start     = accept_flush;

    assign tag_hit  = tag_entry.valid && (tag_entry.tag == addr_q.tag);
    assign word_sel = addr_q.offset[offset_width-1:2];

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (accept_snoop || accept_proc) begin
                    state_d = lookup;
                end else if (accept_flush) begin
                    state_d = flush_wait;
                end
            end
            lookup:    state_d = snoop_q ? snoop_check : respond;
            respond: begin
                if (miss_q || tag_hit) begin
                    state_d = idle;
                end else if (tag_entry.valid && tag_entry.state == m) begin
                    state_d = writeback;  // Dirty victim goes out first
                end else begin
                    state_d = refill;
                end
            end
            writeback: if (bus_req_ready) state_d = refill;
            refill:    if (sent_q && bus_resp_valid) state_d = fill;
            fill:      state_d = respond;
            snoop_check: state_d = idle;
            flush_wait:  if (!flush_busy) state_d = idle;
            default:     state_d = idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= idle;
            run_q   <= 1'b0;
            snoop_q <= 1'b0;
            miss_q  <= 1'b0;
            sent_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
            if (accept_snoop) begin
                snoop_q <= 1'b1;
            end else if (accept_proc) begin
                snoop_q <= 1'b0;
            end
            if (state_q == idle) begin
                miss_q <= 1'b0;
            end else if (state_q == respond && !miss_q && !tag_hit) begin
                miss_q <= 1'b1;
            end
            if (state_q != refill) begin
                sent_q <= 1'b0;
            end else if (bus_req_valid && bus_req_ready) begin
                sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_snoop) begin
            addr_q      <= snoop_req.addr;
            new_state_q <= snoop_req.new_state;
        end else if (accept_proc) begin
            addr_q  <= proc_req.addr;
            write_q <= proc_req.write;
            wdata_q <= proc_req.wdata;
        end
        if (state_q == refill && bus_resp_valid) begin
            fill_line_q  <= bus_resp.line;
            fill_state_q <= bus_resp.state;
        end
    end

    assign tag_lookup_en     = (state_q == lookup);
    assign tag_lookup_index  = addr_q.index;
    assign data_lookup_en    = (state_q == lookup);
    assign data_lookup_index = addr_q.index;

    always_comb begin
        tag_write_en          = 1'b0;
        tag_write_index       = addr_q.index;
        tag_write_entry.tag   = addr_q.tag;
        tag_write_entry.valid = 1'b1;
        tag_write_entry.state = m;
        data_write_en         = 1'b0;
        data_write_index      = addr_q.index;
        data_write_line       = data_line;
        data_word_en          = 1'b0;
        data_word_sel         = word_sel;
        data_word_data        = wdata_q;
        case (state_q)
            respond: begin
                if (!miss_q && tag_hit && write_q) begin  // Write hit
                    tag_write_en  = 1'b1;
                    data_write_en = 1'b1;
                    data_word_en  = 1'b1;
                end
            end
            fill: begin
                tag_write_en          = 1'b1;
                tag_write_entry.state = fill_state_q;
                data_write_en         = 1'b1;
                data_write_line       = fill_line_q;
                data_word_en          = write_q;  // Merge for write-allocate
            end
            snoop_check: begin
                if (tag_hit) begin
                    tag_write_en          = 1'b1;
                    tag_write_entry.valid = (new_state_q != i);
                    tag_write_entry.state = new_state_q;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        proc_resp_valid = (state_q == respond) && (miss_q || tag_hit);
        proc_resp.hit   = !miss_q;
        if (write_q) begin
            proc_resp.rdata = wdata_q;
        end else if (miss_q) begin
            proc_resp.rdata = fill_line_q.words[word_sel];
        end else begin
            proc_resp.rdata = data_line.words[word_sel];
        end
    end

    always_comb begin
        snoop_resp_valid     = (state_q == snoop_check);
        snoop_resp.hit       = tag_hit;
        snoop_resp.data      = data_line.words[word_sel];
        snoop_resp.old_state = tag_hit ? tag_entry.state : i;
    end

    // Victim address in write-back and the requested line otherwise
    always_comb begin
        bus_req_valid     = (state_q == writeback) || (state_q == refill && !sent_q);
        bus_req.write     = (state_q == writeback);
        bus_req.excl      = write_q;
        bus_req.addr      = addr_q;
        bus_req.addr.offset = '0;
        if (state_q == writeback) begin
            bus_req.excl     = 1'b0;
            bus_req.addr.tag = tag_entry.tag;
        end
        bus_req.line.flat = data_line.flat;
    end

endmodule

// ==== l1_cache_top.sv ====
// L1 data cache top joining the controller with the tag and data stores
`timescale 1ns/1ps

module l1_cache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    proc_req_valid,
    output logic                    proc_req_ready,
    input  cache_pkg::proc_req_t    proc_req,
    output logic                    proc_resp_valid,
    output cache_pkg::proc_resp_t   proc_resp,
    output logic                    bus_req_valid,
    input  logic                    bus_req_ready,
    output cache_pkg::bus_req_t     bus_req,
    input  logic                    bus_resp_valid,
    input  cache_pkg::bus_resp_t    bus_resp,
    input  logic                    snoop_req_valid,
    output logic                    snoop_req_ready,
    input  cache_pkg::snoop_req_t   snoop_req,
    output logic                    snoop_resp_valid,
    output cache_pkg::snoop_resp_t  snoop_resp,
    input  logic                    flush_valid,
    output logic                    flush_ready
);
    import cache_pkg::*;

    logic                   tag_lookup_en;
    logic [index_width-1:0] tag_lookup_index;
    tag_entry_t             tag_entry;
    logic                   tag_write_en;
    logic [index_width-1:0] tag_write_index;
    tag_entry_t             tag_write_entry;
    logic                   flush_start;
    logic                   flush_busy;
    logic                   data_lookup_en;
    logic [index_width-1:0] data_lookup_index;
    cache_line_u            data_line;
    logic                   data_write_en;
    logic [index_width-1:0] data_write_index;
    cache_line_u            data_write_line;
    logic                   data_word_en;
    logic [$clog2(words_per_line)-1:0] data_word_sel;
    word_t                  data_word_data;

    cache_ctrl u_ctrl (
        .*
    );

    cache_tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (tag_lookup_en),
        .lookup_index (tag_lookup_index),
        .lookup_entry (tag_entry),
        .write_en     (tag_write_en),
        .write_index  (tag_write_index),
        .write_entry  (tag_write_entry),
        .flush_start  (flush_start),
        .flush_busy   (flush_busy)
    );

    cache_data_store u_data_store (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (data_lookup_en),
        .lookup_index (data_lookup_index),
        .lookup_line  (data_line),
        .write_en     (data_write_en),
        .write_index  (data_write_index),
        .write_line   (data_write_line),
        .word_en      (data_word_en),
        .word_sel     (data_word_sel),
        .word_data    (data_word_data)
    );

endmodule

// ==== tb_bus_memory.sv ====
// Behavioral bus memory answering line refills and storing write-backs with random latency
`timescale 1ns/1ps

module tb_bus_memory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  bus_req_valid,
    output logic                  bus_req_ready,
    input  cache_pkg::bus_req_t   bus_req,
    output logic                  bus_resp_valid,
    output cache_pkg::bus_resp_t  bus_resp
);
    import cache_pkg::*;

    localparam int max_lines = 64;

    logic [27:0] held_addr [max_lines];  // Line address of each written-back line
    cache_line_u held_line [max_lines];
    int          held_count = 0;
    logic        pending;                // Refill accepted and answer not sent yet
    int          wait_count;
    logic [27:0] pend_addr;
    logic        pend_excl;
    cache_line_u fill_line;

    // Untouched words read as their address XOR a fixed mask
    function automatic word_t read_word(input logic [31:0] addr);
        word_t result;
        result = addr ^ 32'h5a5a0000;
        for (int n = 0; n < held_count; n++) begin
            if (held_addr[n] == addr[31:4]) begin
                result = held_line[n].words[addr[3:2]];
            end
        end
        return result;
    endfunction

    task automatic store_line(input logic [27:0] line_addr, input cache_line_u line);
        int slot;
        slot = held_count;
        for (int n = 0; n < held_count; n++) begin
            if (held_addr[n] == line_addr) begin
                slot = n;  // Overwrite an older copy
            end
        end
        if (slot < max_lines) begin
            held_addr[slot] = line_addr;
            held_line[slot] = line;
            if (slot == held_count) begin
                held_count++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h85b212ff));
        bus_req_ready  = 1'b0;
        bus_resp_valid = 1'b0;
        bus_resp       = '0;
        pending        = 1'b0;
        wait_count     = 0;
        forever begin
            @(posedge clk);
            if (rst) begin
                bus_req_ready  <= 1'b0;
                bus_resp_valid <= 1'b0;
                pending = 1'b0;
            end else begin
                bus_resp_valid <= 1'b0;
                if (pending) begin
                    if (wait_count == 0) begin
                        for (int w = 0; w < words_per_line; w++) begin
                            fill_line.words[w] = read_word({pend_addr, 2'(w), 2'b00});
                        end
                        bus_resp.line  <= fill_line;
                        bus_resp.state <= pend_excl ? m : e;  // Ownership for a write miss
                        bus_resp_valid <= 1'b1;
                        pending = 1'b0;
                    end else begin
                        wait_count--;
                    end
                end else if (bus_req_valid && bus_req_ready) begin
                    if (bus_req.write) begin
                        store_line({bus_req.addr.tag, bus_req.addr.index}, bus_req.line);
                    end else begin
                        pending    = 1'b1;
                        wait_count = $urandom_range(3, 0);
                        pend_addr  = {bus_req.addr.tag, bus_req.addr.index};
                        pend_excl  = bus_req.excl;
                    end
                end
                bus_req_ready <= !pending && ($urandom_range(3, 0) != 0);  // Random stalls
            end
        end
    end

endmodule

// ==== tb_l1_cache.sv ====
// Testbench for the L1 data cache applying a table of requests with expected responses
`timescale 1ns/1ps

module tb_l1_cache;
    import cache_pkg::*;

    typedef enum {op_read, op_write, op_snoop, op_flush} op_t;

    logic        clk;
    logic        rst;
    logic        proc_req_valid;
    logic        proc_req_ready;
    proc_req_t   proc_req;
    logic        proc_resp_valid;
    proc_resp_t  proc_resp;
    logic        bus_req_valid;
    logic        bus_req_ready;
    bus_req_t    bus_req;
    logic        bus_resp_valid;
    bus_resp_t   bus_resp;
    logic        snoop_req_valid;
    logic        snoop_req_ready;
    snoop_req_t  snoop_req;
    logic        snoop_resp_valid;
    snoop_resp_t snoop_resp;
    logic        flush_valid;
    logic        flush_ready;

    // Stimulus table held as one queue per column
    string       name_q[$];
    op_t         op_q[$];
    logic [31:0] addr_q[$];
    word_t       wdata_q[$];
    mesi_t       new_state_q[$];
    word_t       exp_data_q[$];
    logic        exp_hit_q[$];
    mesi_t       exp_old_q[$];

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          proc_sent = 0;
    int          snoop_sent = 0;
    int          proc_resp_count = 0;
    int          snoop_resp_count = 0;
    proc_resp_t  got_proc;
    snoop_resp_t got_snoop;

    l1_cache_top uut (
        .clk              (clk),
        .rst              (rst),
        .proc_req_valid   (proc_req_valid),
        .proc_req_ready   (proc_req_ready),
        .proc_req         (proc_req),
        .proc_resp_valid  (proc_resp_valid),
        .proc_resp        (proc_resp),
        .bus_req_valid    (bus_req_valid),
        .bus_req_ready    (bus_req_ready),
        .bus_req          (bus_req),
        .bus_resp_valid   (bus_resp_valid),
        .bus_resp         (bus_resp),
        .snoop_req_valid  (snoop_req_valid),
        .snoop_req_ready  (snoop_req_ready),
        .snoop_req        (snoop_req),
        .snoop_resp_valid (snoop_resp_valid),
        .snoop_resp       (snoop_resp),
        .flush_valid      (flush_valid),
        .flush_ready      (flush_ready)
    );

    tb_bus_memory u_memory (
        .clk            (clk),
        .rst            (rst),
        .bus_req_valid  (bus_req_valid),
        .bus_req_ready  (bus_req_ready),
        .bus_req        (bus_req),
        .bus_resp_valid (bus_resp_valid),
        .bus_resp       (bus_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Word content of memory that was never written back
    function automatic word_t pattern_word(input logic [31:0] addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    task automatic add_entry(input string name, input op_t op, input logic [31:0] addr,
                             input word_t wdata, input mesi_t new_state, input word_t exp_data,
                             input logic exp_hit, input mesi_t exp_old);
        name_q.push_back(name);
        op_q.push_back(op);
        addr_q.push_back(addr);
        wdata_q.push_back(wdata);
        new_state_q.push_back(new_state);
        exp_data_q.push_back(exp_data);
        exp_hit_q.push_back(exp_hit);
        exp_old_q.push_back(exp_old);
    endtask

    task automatic build_table();
        add_entry("read_miss_fresh", op_read, 32'h1040, 0, i, pattern_word(32'h1040), 0, i);
        add_entry("read_hit_same_line", op_read, 32'h1048, 0, i, pattern_word(32'h1048), 1, i);
        add_entry("write_hit", op_write, 32'h1044, 32'hdeadbeef, i, 0, 1, i);
        add_entry("read_after_write", op_read, 32'h1044, 0, i, 32'hdeadbeef, 1, i);
        add_entry("write_allocate", op_write, 32'h2080, 32'h12345678, i, 0, 0, i);
        add_entry("read_alloc_word", op_read, 32'h2080, 0, i, 32'h12345678, 1, i);
        add_entry("read_alloc_neighbor", op_read, 32'h208c, 0, i, pattern_word(32'h208c), 1, i);
        add_entry("read_evict_dirty", op_read, 32'h5044, 0, i, pattern_word(32'h5044), 0, i);
        add_entry("read_written_back", op_read, 32'h1044, 0, i, 32'hdeadbeef, 0, i);
        add_entry("snoop_exclusive", op_snoop, 32'h1044, 0, s, 32'hdeadbeef, 1, e);
        add_entry("snoop_modified", op_snoop, 32'h2080, 0, s, 32'h12345678, 1, m);
        add_entry("read_shared_hit", op_read, 32'h2080, 0, i, 32'h12345678, 1, i);
        add_entry("snoop_invalidate", op_snoop, 32'h1044, 0, i, 32'hdeadbeef, 1, s);
        add_entry("read_after_inval", op_read, 32'h1044, 0, i, 32'hdeadbeef, 0, i);
        add_entry("snoop_absent", op_snoop, 32'h9300, 0, s, 0, 0, i);
        add_entry("write_miss_clean", op_write, 32'h3100, 32'hcafef00d, i, 0, 0, i);
        add_entry("write_hit_again", op_write, 32'h1040, 32'h0badc0de, i, 0, 1, i);
        add_entry("flush_all", op_flush, 32'h0, 0, i, 0, 0, i);
        add_entry("read_flushed_a", op_read, 32'h1040, 0, i, pattern_word(32'h1040), 0, i);
        add_entry("read_refilled_a", op_read, 32'h1044, 0, i, 32'hdeadbeef, 1, i);
        add_entry("read_flushed_d", op_read, 32'h3100, 0, i, pattern_word(32'h3100), 0, i);
        add_entry("read_flushed_b", op_read, 32'h2080, 0, i, pattern_word(32'h2080), 0, i);
        add_entry("write_hit_d", op_write, 32'h3104, 32'h11112222, i, 0, 1, i);
        add_entry("write_miss_dirty", op_write, 32'h8108, 32'h55556666, i, 0, 0, i);
        add_entry("read_back_d", op_read, 32'h3104, 0, i, 32'h11112222, 0, i);
        add_entry("read_back_alloc", op_read, 32'h8108, 0, i, 32'h55556666, 0, i);
    endtask

    task automatic note_mismatch(input string name, input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
        error_count++;
    endtask

    task automatic proc_access(input logic wr, input logic [31:0] addr, input word_t wdata,
                               output proc_resp_t resp);
        @(posedge clk);
        proc_req_valid <= 1'b1;
        proc_req.write <= wr;
        proc_req.addr  <= addr;
        proc_req.wdata <= wdata;
        do @(posedge clk); while (!proc_req_ready);  // Transfer on this edge
        proc_req_valid <= 1'b0;
        proc_sent++;
        do @(posedge clk); while (!proc_resp_valid);
        resp = proc_resp;
    endtask

    task automatic snoop_lookup(input logic [31:0] addr, input mesi_t new_state,
                                output snoop_resp_t resp);
        @(posedge clk);
        snoop_req_valid     <= 1'b1;
        snoop_req.addr      <= addr;
        snoop_req.new_state <= new_state;
        do @(posedge clk); while (!snoop_req_ready);
        snoop_req_valid <= 1'b0;
        snoop_sent++;
        do @(posedge clk); while (!snoop_resp_valid);
        resp = snoop_resp;
    endtask

    task automatic flush_cache();
        @(posedge clk);
        flush_valid <= 1'b1;
        do @(posedge clk); while (!flush_ready);
        flush_valid <= 1'b0;
        do @(posedge clk); while (!flush_ready);  // Sweep finished
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d, proc responses %0d of %0d, snoop responses %0d of %0d",
                 check_count, error_count, proc_resp_count, proc_sent,
                 snoop_resp_count, snoop_sent);
    endtask

    always @(posedge clk) begin
        if (!rst && proc_resp_valid) begin
            proc_resp_count <= proc_resp_count + 1;
        end
        if (!rst && snoop_resp_valid) begin
            snoop_resp_count <= snoop_resp_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rst             = 1'b1;
        proc_req_valid  = 1'b0;
        proc_req        = '0;
        snoop_req_valid = 1'b0;
        snoop_req       = '0;
        flush_valid     = 1'b0;
        build_table();
        cycle_limit = name_q.size() * 300 + 600;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < name_q.size(); t++) begin
            case (op_q[t])
                op_read, op_write: begin
                    proc_access(op_q[t] == op_write, addr_q[t], wdata_q[t], got_proc);
                    check_count++;
                    if (got_proc.hit !== exp_hit_q[t]) begin
                        note_mismatch(name_q[t], "hit", exp_hit_q[t], got_proc.hit);
                    end
                    if (op_q[t] == op_read && got_proc.rdata !== exp_data_q[t]) begin
                        note_mismatch(name_q[t], "rdata", exp_data_q[t], got_proc.rdata);
                    end
                end
                op_snoop: begin
                    snoop_lookup(addr_q[t], new_state_q[t], got_snoop);
                    check_count++;
                    if (got_snoop.hit !== exp_hit_q[t]) begin
                        note_mismatch(name_q[t], "hit", exp_hit_q[t], got_snoop.hit);
                    end
                    if (got_snoop.old_state !== exp_old_q[t]) begin
                        note_mismatch(name_q[t], "old_state", exp_old_q[t], got_snoop.old_state);
                    end
                    if (exp_hit_q[t] && got_snoop.data !== exp_data_q[t]) begin
                        note_mismatch(name_q[t], "data", exp_data_q[t], got_snoop.data);
                    end
                end
                default: begin
                    flush_cache();
                end
            endcase
        end
        repeat (4) @(posedge clk);  // Let any stray response pulse show up
        if (proc_resp_count != proc_sent) begin
            $display("processor responses do not match the number of processor requests");
            error_count++;
        end
        if (snoop_resp_count != snoop_sent) begin
            $display("snoop responses do not match the number of snoop requests");
            error_count++;
        end
        print_counts();
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== l1_cache_top.f ====
cache_pkg.sv
cache_tag_store.sv
cache_data_store.sv
cache_ctrl.sv
l1_cache_top.sv
tb_bus_memory.sv
tb_l1_cache.sv

// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - cache_pkg.sv
  - cache_tag_store.sv
  - cache_data_store.sv
  - cache_ctrl.sv
  - l1_cache_top.sv
  - target: simulation
    files:
      - tb_bus_memory.sv
      - tb_l1_cache.sv
